/* verilog/trap_config.svh */
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// entries between detector and sequencer
`define TRAP_QUEUE_DEPTH 4

// machine-mode CSR addresses
`define CSR_MEPC   12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MTVEC  12'h305

// mcause exception codes
`define CAUSE_MISALIGNED 0
`define CAUSE_BREAKPOINT 3
`define CAUSE_ECALL_M    11

// opcodes and function fields
`define OPC_SYSTEM     7'b1110011
`define OPC_MISC_MEM   7'b0001111
`define FUNCT12_ECALL  12'h000
`define FUNCT12_EBREAK 12'h001
`define FUNCT12_MRET   12'h302
`define FUNCT3_PRIV    3'b000
`define FUNCT3_FENCEI  3'b001

`endif

/* verilog/trap_pkg.sv */
package trap_pkg;

    // what the detector found in a retiring instruction
    typedef enum logic [2:0] {
        trap_none       = 3'd0,
        trap_ecall      = 3'd1,
        trap_ebreak     = 3'd2,
        trap_mret       = 3'd3,
        trap_fencei     = 3'd4,
        trap_misaligned = 3'd5
    } trap_kind_t;

    // one queued trap, 35 bits
    typedef struct packed {
        trap_kind_t  kind;
        logic [31:0] pc;  // address of the retiring instruction
    } trap_req_t;

endpackage

/* verilog/csr_pkg.sv */
package csr_pkg;

    // single write request into the CSR file
    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_write_t;

    // mcause split into its two fields
    typedef struct packed {
        logic        interrupt; // always 0 here, no interrupts
        logic [30:0] code;
    } mcause_fields_t;

    // same word seen raw or by field
    typedef union packed {
        logic [31:0]    raw;
        mcause_fields_t fields;
    } mcause_u;

endpackage

/* verilog/trap_detect.sv */
`timescale 1ns/1ns
`include "trap_config.svh"

module trap_detect (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    output logic                instr_ready,
    input  logic [31:0]         instr,
    input  logic [31:0]         pc,
    input  logic [31:0]         next_pc,
    output logic                req_valid,
    input  logic                req_ready,
    output trap_pkg::trap_req_t req
);

    trap_pkg::trap_kind_t kind;
    logic                 accept;
    logic                 is_trap;

    always_comb begin
        kind = trap_pkg::trap_none;
        if (next_pc[1:0] != 2'b00) begin
            kind = trap_pkg::trap_misaligned; // beats any decode below
        end else if (instr[6:0] == `OPC_SYSTEM && instr[14:12] == `FUNCT3_PRIV) begin
            case (instr[31:20])
                `FUNCT12_ECALL:  kind = trap_pkg::trap_ecall;
                `FUNCT12_EBREAK: kind = trap_pkg::trap_ebreak;
                `FUNCT12_MRET:   kind = trap_pkg::trap_mret;
                default:         kind = trap_pkg::trap_none;
            endcase
        end else if (instr[6:0] == `OPC_MISC_MEM && instr[14:12] == `FUNCT3_FENCEI) begin
            kind = trap_pkg::trap_fencei;
        end
    end

    // stall only while a request sits unaccepted
    assign instr_ready = !req_valid || req_ready;
    assign accept      = instr_valid && instr_ready;
    assign is_trap     = (kind != trap_pkg::trap_none);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (accept && is_trap) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0; // plain instructions just fall through
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_trap) begin
            req.kind <= kind;
            req.pc   <= pc;
        end
    end

endmodule

/* verilog/trap_queue.sv */
`timescale 1ns/1ns
`include "trap_config.svh"

module trap_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  trap_pkg::trap_req_t in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output trap_pkg::trap_req_t out_data
);

    localparam int depth = `TRAP_QUEUE_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    trap_pkg::trap_req_t mem [0:depth-1];
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [cnt_w-1:0]    count;
    logic                push;
    logic                pop;

    // wraps at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(depth - 1)) return '0;
        return p + 1'b1;
    endfunction

    assign in_ready  = (count != cnt_w'(depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr]; // head entry
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

/* verilog/trap_sequencer.sv */
`timescale 1ns/1ns
`include "trap_config.svh"

module trap_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  trap_pkg::trap_req_t  req,
    output csr_pkg::csr_write_t  csr_wr,
    output logic [11:0]          csr_raddr,
    input  logic [31:0]          csr_rdata,
    output logic                 redirect_valid,
    output logic [31:0]          redirect_target,
    output logic                 ic_flush,
    output logic                 debug_mode
);

    // named after what is on the outputs during the state
    typedef enum logic [1:0] {
        st_idle,
        st_mepc,
        st_mcause,
        st_mtvec
    } state_t;

    state_t               state;
    trap_pkg::trap_kind_t cur_kind;
    csr_pkg::mcause_u     cause;
    logic                 accept;

    assign req_ready = (state == st_idle);
    assign accept    = req_valid && req_ready;
    // mtvec is sampled on the way out of st_mcause, mepc otherwise (mret)
    assign csr_raddr = (state == st_mcause) ? `CSR_MTVEC : `CSR_MEPC;

    always_comb begin
        cause.fields.interrupt = 1'b0;
        case (cur_kind)
            trap_pkg::trap_ecall:  cause.fields.code = 31'(`CAUSE_ECALL_M);
            trap_pkg::trap_ebreak: cause.fields.code = 31'(`CAUSE_BREAKPOINT);
            default:               cause.fields.code = 31'(`CAUSE_MISALIGNED);
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= st_idle;
            cur_kind        <= trap_pkg::trap_none;
            csr_wr          <= '0;
            redirect_valid  <= 1'b0;
            redirect_target <= '0;
            ic_flush        <= 1'b0;
            debug_mode      <= 1'b0;
        end else begin
            // single-cycle pulses, debug_mode is sticky
            csr_wr.en      <= 1'b0;
            redirect_valid <= 1'b0;
            ic_flush       <= 1'b0;
            case (state)
                st_idle: if (accept) begin
                    cur_kind <= req.kind;
                    case (req.kind)
                        trap_pkg::trap_ecall, trap_pkg::trap_misaligned,
                        trap_pkg::trap_ebreak: begin
                            csr_wr <= '{en: 1'b1, addr: `CSR_MEPC, data: req.pc};
                            state  <= st_mepc;
                            if (req.kind == trap_pkg::trap_ebreak) debug_mode <= 1'b1;
                        end
                        trap_pkg::trap_mret: begin
                            redirect_valid  <= 1'b1;
                            redirect_target <= csr_rdata + 32'd4; // skip the ecall
                            debug_mode      <= 1'b0;
                        end
                        trap_pkg::trap_fencei: ic_flush <= 1'b1;
                        default: ;
                    endcase
                end
                st_mepc: begin
                    csr_wr <= '{en: 1'b1, addr: `CSR_MCAUSE, data: cause.raw};
                    state  <= st_mcause;
                end
                st_mcause: begin
                    if (cur_kind == trap_pkg::trap_ebreak) begin
                        state <= st_idle; // debugger takes over, no redirect
                    end else begin
                        redirect_valid  <= 1'b1;
                        redirect_target <= csr_rdata;
                        state           <= st_mtvec;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* verilog/csr_file.sv */
`timescale 1ns/1ns
`include "trap_config.svh"

module csr_file (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_write_t wr,
    input  csr_pkg::csr_write_t ext_wr,
    input  logic [11:0]         raddr,
    output logic [31:0]         rdata
);

    logic [31:0]      mepc;
    csr_pkg::mcause_u mcause;
    logic [31:0]      mtvec;

    function automatic logic hit(input csr_pkg::csr_write_t w, input logic [11:0] addr);
        return w.en && (w.addr == addr);
    endfunction

    // sequencer port first, external port only if it leaves the register alone
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mepc       <= '0;
            mcause.raw <= '0;
            mtvec      <= '0;
        end else begin
            if (hit(wr, `CSR_MEPC)) mepc <= wr.data;
            else if (hit(ext_wr, `CSR_MEPC)) mepc <= ext_wr.data;

            if (hit(wr, `CSR_MCAUSE)) mcause.raw <= wr.data;
            else if (hit(ext_wr, `CSR_MCAUSE)) mcause.raw <= ext_wr.data;

            if (hit(wr, `CSR_MTVEC)) mtvec <= wr.data;
            else if (hit(ext_wr, `CSR_MTVEC)) mtvec <= ext_wr.data;
        end
    end

    always_comb begin
        case (raddr)
            `CSR_MEPC:   rdata = mepc;
            `CSR_MCAUSE: rdata = mcause.raw;
            `CSR_MTVEC:  rdata = mtvec;
            default:     rdata = '0; // unimplemented reads as zero
        endcase
    end

endmodule

/* verilog/trap_unit.sv */
`timescale 1ns/1ns

module trap_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    output logic                instr_ready,
    input  logic [31:0]         instr,
    input  logic [31:0]         pc,
    input  logic [31:0]         next_pc,
    input  csr_pkg::csr_write_t mtvec_wr,
    output csr_pkg::csr_write_t csr_wr,
    output logic                redirect_valid,
    output logic [31:0]         redirect_target,
    output logic                ic_flush,
    output logic                debug_mode
);

    logic                det_valid;  // detector to queue
    logic                det_ready;
    trap_pkg::trap_req_t det_req;
    logic                seq_valid;  // queue to sequencer
    logic                seq_ready;
    trap_pkg::trap_req_t seq_req;
    logic [11:0]         csr_raddr;
    logic [31:0]         csr_rdata;

    trap_detect u_detect (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .pc          (pc),
        .next_pc     (next_pc),
        .req_valid   (det_valid),
        .req_ready   (det_ready),
        .req         (det_req)
    );

    trap_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (det_valid),
        .in_ready  (det_ready),
        .in_data   (det_req),
        .out_valid (seq_valid),
        .out_ready (seq_ready),
        .out_data  (seq_req)
    );

    trap_sequencer u_sequencer (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (seq_valid),
        .req_ready       (seq_ready),
        .req             (seq_req),
        .csr_wr          (csr_wr),    // also the trace output
        .csr_raddr       (csr_raddr),
        .csr_rdata       (csr_rdata),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .ic_flush        (ic_flush),
        .debug_mode      (debug_mode)
    );

    csr_file u_csr (
        .clk    (clk),
        .rst    (rst),
        .wr     (csr_wr),
        .ext_wr (mtvec_wr),
        .raddr  (csr_raddr),
        .rdata  (csr_rdata)
    );

endmodule

/* bench/trap_unit_checker.sv */
`timescale 1ns/1ns
`include "trap_config.svh"

module trap_unit_checker (
    input logic                clk,
    input logic                rst,
    input logic                instr_valid,
    input logic                instr_ready,
    input logic [31:0]         instr,
    input logic [31:0]         pc,
    input logic [31:0]         next_pc,
    input csr_pkg::csr_write_t mtvec_wr,
    input csr_pkg::csr_write_t csr_wr,
    input logic                redirect_valid,
    input logic [31:0]         redirect_target,
    input logic                ic_flush,
    input logic                debug_mode,
    input logic                det_valid,
    input logic                seq_valid,
    input logic                seq_ready,
    input trap_pkg::trap_req_t seq_req,
    input logic [$clog2(`TRAP_QUEUE_DEPTH + 1)-1:0] queue_count
);

    int                   errors = 0; // watched by the testbench
    logic                 started;
    logic [31:0]          mtvec_seen;
    logic [31:0]          mepc_seen;  // last mepc on the trace port
    logic [31:0]          last_pc;
    logic [31:0]          last_cause;
    logic [31:0]          exp_cause;
    trap_pkg::trap_req_t  model [0:7];
    trap_pkg::trap_req_t  model_head;
    logic [2:0]           head;
    logic [2:0]           tail;
    logic [3:0]           pending;
    trap_pkg::trap_kind_t top_kind;
    logic                 top_push;
    logic                 seq_acc;
    logic                 acc_csr;
    logic                 acc_jump;

    // RISC-V privileged encodings, rs1 and rd zero
    function automatic trap_pkg::trap_kind_t expected_kind(input logic [31:0] i,
                                                           input logic [31:0] npc);
        if (npc[1:0] != 2'b00) return trap_pkg::trap_misaligned;
        if (i[6:0] == `OPC_SYSTEM && i[19:7] == 13'd0) begin
            if (i[31:20] == `FUNCT12_ECALL) return trap_pkg::trap_ecall;
            if (i[31:20] == `FUNCT12_EBREAK) return trap_pkg::trap_ebreak;
            if (i[31:20] == `FUNCT12_MRET) return trap_pkg::trap_mret;
        end
        if (i[6:0] == `OPC_MISC_MEM && i[14:12] == `FUNCT3_FENCEI) return trap_pkg::trap_fencei;
        return trap_pkg::trap_none;
    endfunction

    always_comb begin
        case (seq_req.kind)
            trap_pkg::trap_ecall:  exp_cause = `CAUSE_ECALL_M;
            trap_pkg::trap_ebreak: exp_cause = `CAUSE_BREAKPOINT;
            default:               exp_cause = `CAUSE_MISALIGNED;
        endcase
    end

    assign top_kind   = expected_kind(instr, next_pc);
    assign top_push   = instr_valid && instr_ready && top_kind != trap_pkg::trap_none;
    assign seq_acc    = seq_valid && seq_ready;
    assign acc_jump   = seq_acc && (seq_req.kind == trap_pkg::trap_ecall ||
                                    seq_req.kind == trap_pkg::trap_misaligned);
    assign acc_csr    = acc_jump || (seq_acc && seq_req.kind == trap_pkg::trap_ebreak);
    assign model_head = model[head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started    <= 1'b0;
            mtvec_seen <= '0;
            mepc_seen  <= '0;
            last_pc    <= '0;
            last_cause <= '0;
            head       <= '0;
            tail       <= '0;
            pending    <= '0;
        end else begin
            if (mtvec_wr.en && mtvec_wr.addr == `CSR_MTVEC) mtvec_seen <= mtvec_wr.data;
            if (csr_wr.en && csr_wr.addr == `CSR_MEPC) mepc_seen <= csr_wr.data;
            if (top_push) begin
                model[tail] <= '{kind: top_kind, pc: pc};
                tail        <= tail + 1'b1;
            end
            if (seq_acc) begin
                started    <= 1'b1;
                last_pc    <= seq_req.pc;
                last_cause <= exp_cause;
                head       <= head + 1'b1;
            end
            pending <= pending + 4'(top_push) - 4'(seq_acc);
        end
    end

    a_quiet: assert property (@(posedge clk) !started |->
        !redirect_valid && !ic_flush && !debug_mode && !csr_wr.en)
        else begin
            errors++;
            $error("Fail at %0t: redirect/flush/debug/csr_wr.en = %b%b%b%b, expected 0000",
                $time, redirect_valid, ic_flush, debug_mode, csr_wr.en);
        end

    a_trap_csrs: assert property (@(posedge clk) disable iff (rst) acc_csr |=>
        (csr_wr.en && csr_wr.addr == `CSR_MEPC && csr_wr.data == last_pc) ##1
        (csr_wr.en && csr_wr.addr == `CSR_MCAUSE && csr_wr.data == last_cause))
        else begin
            errors++;
            $error("Fail at %0t: csr_wr = %b/%h/%h, expected mepc %h then mcause %0d",
                $time, csr_wr.en, csr_wr.addr, csr_wr.data, last_pc, last_cause);
        end

    a_redirect: assert property (@(posedge clk) disable iff (rst) acc_jump |->
        ##3 (redirect_valid && redirect_target == mtvec_seen))
        else begin
            errors++;
            $error("Fail at %0t: redirect_target = %h (valid %b), expected %h",
                $time, redirect_target, redirect_valid, mtvec_seen);
        end

    a_debug_rise: assert property (@(posedge clk) disable iff (rst)
        seq_acc && seq_req.kind == trap_pkg::trap_ebreak |=> debug_mode)
        else begin
            errors++;
            $error("Fail at %0t: debug_mode = %b, expected 1", $time, debug_mode);
        end

    a_debug_hold: assert property (@(posedge clk) disable iff (rst)
        debug_mode && !(seq_acc && seq_req.kind == trap_pkg::trap_mret) |=> debug_mode)
        else begin
            errors++;
            $error("Fail at %0t: debug_mode dropped without an mret", $time);
        end

    a_mret: assert property (@(posedge clk) disable iff (rst)
        seq_acc && seq_req.kind == trap_pkg::trap_mret |=>
        redirect_valid && redirect_target == mepc_seen + 32'd4 && !debug_mode)
        else begin
            errors++;
            $error("Fail at %0t: redirect_target = %h, expected %h, debug_mode = %b",
                $time, redirect_target, mepc_seen + 32'd4, debug_mode);
        end

    a_fencei: assert property (@(posedge clk) disable iff (rst)
        seq_acc && seq_req.kind == trap_pkg::trap_fencei |=> ic_flush && !csr_wr.en)
        else begin
            errors++;
            $error("Fail at %0t: ic_flush = %b csr_wr.en = %b, expected 1 and 0",
                $time, ic_flush, csr_wr.en);
        end

    a_flush_src: assert property (@(posedge clk) disable iff (rst)
        ic_flush |-> $past(seq_acc && seq_req.kind == trap_pkg::trap_fencei))
        else begin
            errors++;
            $error("Fail at %0t: ic_flush pulsed without a fence.i", $time);
        end

    a_order: assert property (@(posedge clk) disable iff (rst)
        seq_acc |-> pending != 0 && seq_req == model_head)
        else begin
            errors++;
            $error("Fail at %0t: seq_req = %h, expected %h", $time, seq_req, model_head);
        end

    a_drained: assert property (@(posedge clk) disable iff (rst)
        !det_valid && queue_count == 0 |-> pending == 0)
        else begin
            errors++;
            $error("Fail at %0t: %0d trap requests lost", $time, pending);
        end

    a_depth: assert property (@(posedge clk) disable iff (rst)
        queue_count <= `TRAP_QUEUE_DEPTH)
        else begin
            errors++;
            $error("Fail at %0t: queue_count = %0d, expected at most %0d",
                $time, queue_count, `TRAP_QUEUE_DEPTH);
        end

    a_full_stall: assert property (@(posedge clk) disable iff (rst)
        det_valid && queue_count == `TRAP_QUEUE_DEPTH |-> !instr_ready)
        else begin
            errors++;
            $error("Fail at %0t: instr_ready = %b, expected 0 with a full queue",
                $time, instr_ready);
        end

endmodule

bind trap_unit trap_unit_checker chk (.*, .queue_count(u_queue.count));

/* bench/trap_unit_tb.sv */
`timescale 1ns/1ns
`include "trap_config.svh"

module trap_unit_tb;

    localparam int num_instr  = 200;
    localparam int max_cycles = num_instr * 20;

    logic                clk = 1'b0;
    logic                rst;
    logic                instr_valid;
    logic                instr_ready;
    logic [31:0]         instr;
    logic [31:0]         pc;
    logic [31:0]         next_pc;
    csr_pkg::csr_write_t mtvec_wr;
    csr_pkg::csr_write_t csr_wr;
    logic                redirect_valid;
    logic [31:0]         redirect_target;
    logic                ic_flush;
    logic                debug_mode;
    int                  seed = 27319;
    logic [31:0]         cur_pc;

    trap_unit uut (.*);

    always #50 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] pick_word(input int sel);
        case (sel)
            3:       return 32'h0000_0073; // ecall
            4:       return 32'h0010_0073; // ebreak
            5:       return 32'h3020_0073; // mret
            6:       return 32'h0000_100f; // fence.i
            default: return 32'h0010_8093; // addi x1, x1, 1
        endcase
    endfunction

    // hold the instruction until the detector takes it
    task automatic retire(input logic [31:0] word, input logic odd_target);
        logic taken;
        instr_valid = 1'b1;
        instr       = word;
        pc          = cur_pc;
        next_pc     = odd_target ? cur_pc + 32'd2 : cur_pc + 32'd4;
        do begin
            @(negedge clk);
            taken = instr_ready; // stable mid cycle
            @(posedge clk);
            #10;
        end while (!taken);
        instr_valid = 1'b0;
        cur_pc      = cur_pc + 32'd4;
    endtask

    initial begin
        int sel;
        int gap;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        next_pc     = '0;
        mtvec_wr    = '0;
        cur_pc      = 32'h0000_1000;
        repeat (16) @(posedge clk);
        #10;
        rst      = 1'b0;
        mtvec_wr = '{en: 1'b1, addr: `CSR_MTVEC, data: 32'h0000_0200};
        @(posedge clk);
        #10;
        mtvec_wr = '0;
        repeat (8) retire(pick_word(3), 1'b0); // ecall burst overruns the queue
        for (int n = 8; n < num_instr; n++) begin
            sel = $random(seed) & 7;
            gap = $random(seed) & 7;
            if (gap > 4) begin
                repeat (gap - 4) @(posedge clk);
                #10;
            end
            retire(pick_word(sel), sel == 7); // 7 is a misaligned jump
        end
        while (uut.det_valid || uut.seq_valid || !uut.seq_ready) begin
            @(posedge clk);
            #10;
        end
        repeat (4) @(posedge clk); // margin after the last trap
        #10;
        if (uut.chk.errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_run("checker reported assertion failures");
        end
    end

    always @(negedge clk) begin
        if (uut.chk.errors != 0) fail_run("an assertion in the checker failed");
    end

    // watchdog
    initial begin
        repeat (max_cycles) @(posedge clk);
        fail_run("timeout: instruction stream did not finish in time");
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/trap_pkg.sv
verilog/csr_pkg.sv
verilog/trap_detect.sv
verilog/trap_queue.sv
verilog/trap_sequencer.sv
verilog/csr_file.sv
verilog/trap_unit.sv
bench/trap_unit_checker.sv
bench/trap_unit_tb.sv
